// File: src/vicii_pkg.sv
`default_nettype none

package vicii_pkg;

   // chip codes, selected at build time on the top level
   localparam logic [1:0] CHIP_6567R8   = 2'd0;
   localparam logic [1:0] CHIP_6567R56A = 2'd1;
   localparam logic [1:0] CHIP_6569     = 2'd2;

   // beam counter widths
   localparam int RASTER_X_W  = 10;
   localparam int RASTER_Y_W  = 9;
   // cycle number is raster_x / 8
   localparam int CYCLE_NUM_W = 7;

   // dot4x ticks per phi phase
   localparam int PHI_HALF = 16;

   // register file
   localparam int REG_ADDR_W = 6;
   localparam logic [REG_ADDR_W-1:0] ADDR_CTRL1      = 6'h11;
   localparam logic [REG_ADDR_W-1:0] ADDR_RASTER     = 6'h12;
   localparam logic [REG_ADDR_W-1:0] ADDR_IRQ_STATUS = 6'h19;
   localparam logic [REG_ADDR_W-1:0] ADDR_IRQ_ENABLE = 6'h1a;

   // lines on which badlines may occur, last one exclusive
   localparam logic [RASTER_Y_W-1:0] BADLINE_FIRST = 9'd48;
   localparam logic [RASTER_Y_W-1:0] BADLINE_LAST  = 9'd248;

   // cycles with ba low on a badline, both inclusive
   localparam logic [CYCLE_NUM_W-1:0] BA_FIRST_CYCLE = 7'd12;
   localparam logic [CYCLE_NUM_W-1:0] BA_LAST_CYCLE  = 7'd54;

   // control register 1 ($d011)
   // raw view for the bus, field view for the video logic
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         // raster compare bit 8 on write, raster line bit 8 on read
         logic       rst8;
         // extended colour mode
         logic       ecm;
         // bitmap mode
         logic       bmm;
         // display enable
         logic       den;
         // 24/25 row select
         logic       rsel;
         // vertical fine scroll
         logic [2:0] yscroll;
      } f;
   } ctrl1_u;

endpackage

`default_nettype wire

// File: src/vicii_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vicii_timing (
   input  wire  clk_dot4x,
   input  wire  rst,
   output logic clk_phi,
   output logic phase_start_0,
   output logic phase_end,
   output logic dot_rising
);

   import vicii_pkg::*;

   // one full phi period of ticks
   localparam int PHI_RING_W = 2 * PHI_HALF;

   // rings rotate left, bit 0 is the current tick
   logic [PHI_RING_W-1:0] phi_ring;
   logic [PHI_HALF-1:0]   phase_ring;
   logic [3:0]            dot_ring;

   // phi ring
   // after reset phi is low for PHI_HALF ticks, then high
   // bits PHI_HALF..1 reach bit 0 after the low half has passed
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring <= {{(PHI_HALF-1){1'b0}}, {PHI_HALF{1'b1}}, 1'b0};
      end else begin
         phi_ring <= {phi_ring[PHI_RING_W-2:0], phi_ring[PHI_RING_W-1]};
      end
   end

   // single one marks the first tick of each half phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase_ring <= {{(PHI_HALF-1){1'b0}}, 1'b1};
      end else begin
         phase_ring <= {phase_ring[PHI_HALF-2:0], phase_ring[PHI_HALF-1]};
      end
   end

   // dot strobe lands on the last tick of each group of four
   // so raster_x steps in line with the phi cycle boundary
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         dot_ring <= 4'b0010;
      end else begin
         dot_ring <= {dot_ring[2:0], dot_ring[3]};
      end
   end

   assign clk_phi       = phi_ring[0];
   assign phase_start_0 = phase_ring[0];
   // one more rotation brings the marker back to bit 0
   assign phase_end     = phase_ring[PHI_HALF-1];
   assign dot_rising    = dot_ring[0];

   // phase start comes back exactly every PHI_HALF ticks
   a_phase_period: assert property (@(posedge clk_dot4x) disable iff (rst)
      phase_start_0 |=> !phase_start_0 [*(PHI_HALF-1)] ##1 phase_start_0);

   // phi only ever flips on a phase start tick
   a_phi_edge: assert property (@(posedge clk_dot4x) disable iff (rst)
      $changed(clk_phi) |-> phase_start_0);

endmodule

`default_nettype wire

// File: src/vicii_raster.sv
`timescale 1ns/10ps
`default_nettype none

module vicii_raster #(
   parameter logic [1:0] CHIP = vicii_pkg::CHIP_6567R8
) (
   input  wire                                clk_dot4x,
   input  wire                                rst,
   input  wire                                clk_phi,
   input  wire                                phase_start_0,
   input  wire                                dot_rising,
   output logic [vicii_pkg::RASTER_X_W-1:0]  raster_x,
   output logic [vicii_pkg::RASTER_Y_W-1:0]  raster_line,
   output logic [vicii_pkg::RASTER_Y_W-1:0]  raster_line_d,
   output logic [vicii_pkg::CYCLE_NUM_W-1:0] cycle_num
);

   import vicii_pkg::*;

   // last pixel of a line
   // lines are 520 pixels for R8, 512 for R56A and 504 for 6569
   localparam logic [RASTER_X_W-1:0] X_MAX =
      (CHIP == CHIP_6567R8)   ? RASTER_X_W'(519) :
      (CHIP == CHIP_6567R56A) ? RASTER_X_W'(511) :
                                RASTER_X_W'(503);

   // last line of a frame
   // 263, 262 or 312 lines
   localparam logic [RASTER_Y_W-1:0] Y_MAX =
      (CHIP == CHIP_6567R8)   ? RASTER_Y_W'(262) :
      (CHIP == CHIP_6567R56A) ? RASTER_Y_W'(261) :
                                RASTER_Y_W'(311);

   // beam position moves one pixel per dot strobe
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= '0;
         raster_line <= '0;
      end else if (dot_rising) begin
         if (raster_x == X_MAX) begin
            raster_x <= '0;
            // new line starts together with cycle 0
            if (raster_line == Y_MAX) begin
               raster_line <= '0;
            end else begin
               raster_line <= raster_line + 1'b1;
            end
         end else begin
            raster_x <= raster_x + 1'b1;
         end
      end
   end

   // line as seen by the irq compare and badline logic
   // lags the beam until the first phi high of the line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line_d <= '0;
      end else if (clk_phi && phase_start_0) begin
         raster_line_d <= raster_line;
      end
   end

   // eight pixels per phi cycle
   assign cycle_num = raster_x[RASTER_X_W-1:3];

endmodule

`default_nettype wire

// File: src/vicii_registers.sv
`timescale 1ns/10ps
`default_nettype none

module vicii_registers (
   input  wire                               clk_dot4x,
   input  wire                               rst,
   input  wire                               clk_phi,
   input  wire                               phase_start_0,
   input  wire                               phase_end,
   input  wire                               ce,
   input  wire                               rw,
   input  wire [vicii_pkg::REG_ADDR_W-1:0]   adi,
   input  wire [7:0]                         dbi,
   input  wire [vicii_pkg::RASTER_Y_W-1:0]   raster_line,
   input  wire [vicii_pkg::RASTER_Y_W-1:0]   raster_line_d,
   output logic [7:0]                        dbo,
   output logic                              irq,
   output vicii_pkg::ctrl1_u                 ctrl1_d,
   output logic                              den
);

   import vicii_pkg::*;

   // control register 1 as written
   // bit 7 doubles as raster compare bit 8
   ctrl1_u ctrl1;
   // raster compare bits 7..0
   logic [7:0] raster_cmp_lo;
   logic [RASTER_Y_W-1:0] raster_cmp;

   // raster irq latch and enable
   logic irst;
   logic erst;
   // latch already set on this line
   logic irst_fired;

   // read strobe one tick into the phase
   logic phase_start_1;
   logic phi_high_start;
   logic reg_write;
   logic reg_read;
   logic [7:0] rd_data;

   assign phi_high_start = clk_phi & phase_start_0;
   // cpu owns the bus for the whole phi high phase
   assign reg_write = clk_phi & phase_end & ~ce & ~rw;
   assign reg_read  = clk_phi & phase_start_1 & ~ce & rw;

   assign raster_cmp = {ctrl1.f.rst8, raster_cmp_lo};
   assign den        = ctrl1.f.den;

   // condition is latched even when disabled
   // enabling later raises irq at once
   assign irq = irst & erst;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase_start_1 <= 1'b0;
      end else begin
         phase_start_1 <= phase_start_0;
      end
   end

   // cpu writes land at the end of phi high
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1.raw     <= 8'h00;
         raster_cmp_lo <= 8'h00;
         erst          <= 1'b0;
      end else if (reg_write) begin
         case (adi)
            ADDR_CTRL1:      ctrl1.raw <= dbi;
            ADDR_RASTER:     raster_cmp_lo <= dbi;
            ADDR_IRQ_ENABLE: erst <= dbi[0];
            default: ;
         endcase
      end
   end

   // read mux
   // unused bits read back as ones like the real chip
   always_comb begin
      case (adi)
         ADDR_CTRL1:      rd_data = {raster_line[8], ctrl1.raw[6:0]};
         ADDR_RASTER:     rd_data = raster_line[7:0];
         ADDR_IRQ_STATUS: rd_data = {irq, 3'b111, 3'b000, irst};
         ADDR_IRQ_ENABLE: rd_data = {4'hf, 3'b000, erst};
         default:         rd_data = 8'hff;
      endcase
   end

   // read data holds until the next read
   always_ff @(posedge clk_dot4x) begin
      if (reg_read) begin
         dbo <= rd_data;
      end
   end

   // raster irq fires once per line on the delayed line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst       <= 1'b0;
         irst_fired <= 1'b0;
      end else begin
         if (phi_high_start) begin
            if (raster_line_d == raster_cmp) begin
               if (!irst_fired) begin
                  irst_fired <= 1'b1;
                  irst       <= 1'b1;
               end
            end else begin
               // line moved on so rearm
               irst_fired <= 1'b0;
            end
         end
         // write one to clear
         if (reg_write && adi == ADDR_IRQ_STATUS && dbi[0]) begin
            irst <= 1'b0;
         end
      end
   end

   // control word as seen by the badline logic
   // bit 7 carries the beam line bit 8
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1_d.raw <= 8'h00;
      end else if (phi_high_start) begin
         ctrl1_d.raw <= {raster_line[8], ctrl1.raw[6:0]};
      end
   end

   a_irq_enabled: assert property (@(posedge clk_dot4x) disable iff (rst)
      $rose(irq) |-> erst);

endmodule

`default_nettype wire

// File: src/vicii_badline.sv
`timescale 1ns/10ps
`default_nettype none

module vicii_badline (
   input  wire                                clk_dot4x,
   input  wire                                rst,
   input  wire                                clk_phi,
   input  wire                                phase_start_0,
   input  wire                                phase_end,
   input  wire                                den,
   input  wire vicii_pkg::ctrl1_u             ctrl1_d,
   input  wire [vicii_pkg::RASTER_Y_W-1:0]    raster_line,
   input  wire [vicii_pkg::RASTER_Y_W-1:0]    raster_line_d,
   input  wire [vicii_pkg::CYCLE_NUM_W-1:0]   cycle_num,
   output logic                               ba,
   output logic                               aec
);

   import vicii_pkg::*;

   logic allow_bad_lines;
   logic badline;
   logic in_ba_window;
   // ba history sampled at the end of each phi low
   logic ba1;
   logic ba2;
   logic ba3;
   logic phi_low_end;

   assign phi_low_end = ~clk_phi & phase_end;

   // den only counts while the beam is on line 48
   // window closes again on line 248
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
      end else if (clk_phi && phase_start_0) begin
         if (raster_line == BADLINE_FIRST && den) begin
            allow_bad_lines <= 1'b1;
         end
         if (raster_line == BADLINE_LAST) begin
            allow_bad_lines <= 1'b0;
         end
      end
   end

   // delayed line and delayed yscroll, both taken at phi high start
   always_comb begin
      badline = 1'b0;
      if (allow_bad_lines &&
          raster_line_d[2:0] == ctrl1_d.f.yscroll &&
          raster_line_d >= BADLINE_FIRST &&
          raster_line_d < BADLINE_LAST) begin
         badline = 1'b1;
      end
   end

   // c-access cycles plus three cycles of warning
   assign in_ba_window = (cycle_num >= BA_FIRST_CYCLE) && (cycle_num <= BA_LAST_CYCLE);

   assign ba = ~(badline & in_ba_window);

   // ba3 falls once ba has been low for three samples
   // sampled just before phi rises so the high phase sees it whole
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (phi_low_end) begin
         ba1 <= ba;
         ba2 <= ba1 | ba;
         ba3 <= ba2 | ba;
      end
   end

   // aec tracks phi one tick late
   // cpu keeps its high phases until the cascade runs out
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec <= 1'b0;
      end else begin
         aec <= ba ? clk_phi : (ba3 & clk_phi);
      end
   end

   // vic owns the bus in phi low, past the first tick of delay
   a_aec_low_phase: assert property (@(posedge clk_dot4x) disable iff (rst)
      (!clk_phi && !phase_start_0) |-> !aec);

endmodule

`default_nettype wire

// File: src/vicii_top.sv
`timescale 1ns/10ps
`default_nettype none

module vicii_top #(
   parameter logic [1:0] CHIP = vicii_pkg::CHIP_6567R8
) (
   input  wire                                clk_dot4x,
   input  wire                                rst,
   // cpu bus
   input  wire                                ce,
   input  wire                                rw,
   input  wire [vicii_pkg::REG_ADDR_W-1:0]    adi,
   input  wire [7:0]                          dbi,
   output logic [7:0]                         dbo,
   output logic                               irq,
   // bus arbitration
   output logic                               ba,
   output logic                               aec,
   // timing
   output logic                               clk_phi,
   output logic [vicii_pkg::RASTER_X_W-1:0]   raster_x,
   output logic [vicii_pkg::RASTER_Y_W-1:0]   raster_line
);

   import vicii_pkg::*;

   // strobes from the timing rings
   logic phase_start_0;
   logic phase_end;
   logic dot_rising;

   logic [RASTER_Y_W-1:0]  raster_line_d;
   logic [CYCLE_NUM_W-1:0] cycle_num;

   // control word for the badline logic
   ctrl1_u ctrl1_d;
   logic   den;

   vicii_timing u_timing (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi       (clk_phi),
      .phase_start_0 (phase_start_0),
      .phase_end     (phase_end),
      .dot_rising    (dot_rising)
   );

   vicii_raster #(
      .CHIP (CHIP)
   ) u_raster (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi       (clk_phi),
      .phase_start_0 (phase_start_0),
      .dot_rising    (dot_rising),
      .raster_x      (raster_x),
      .raster_line   (raster_line),
      .raster_line_d (raster_line_d),
      .cycle_num     (cycle_num)
   );

   vicii_registers u_registers (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi       (clk_phi),
      .phase_start_0 (phase_start_0),
      .phase_end     (phase_end),
      .ce            (ce),
      .rw            (rw),
      .adi           (adi),
      .dbi           (dbi),
      .raster_line   (raster_line),
      .raster_line_d (raster_line_d),
      .dbo           (dbo),
      .irq           (irq),
      .ctrl1_d       (ctrl1_d),
      .den           (den)
   );

   vicii_badline u_badline (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi       (clk_phi),
      .phase_start_0 (phase_start_0),
      .phase_end     (phase_end),
      .den           (den),
      .ctrl1_d       (ctrl1_d),
      .raster_line   (raster_line),
      .raster_line_d (raster_line_d),
      .cycle_num     (cycle_num),
      .ba            (ba),
      .aec           (aec)
   );

endmodule

`default_nettype wire

// File: bench/vicii_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vicii_tb;

   import vicii_pkg::*;

   // one frame of the default chip is 263 * 520 * 4 ticks
   localparam int FRAME_TICKS = 600000;
   localparam int X_LAST = 519;
   localparam int Y_LAST = 262;

   logic       clk_dot4x;
   logic       rst;
   logic       ce;
   logic       rw;
   logic [5:0] adi;
   logic [7:0] dbi;
   wire  [7:0] dbo;
   wire        irq;
   wire        ba;
   wire        aec;
   wire        clk_phi;
   wire  [9:0] raster_x;
   wire  [8:0] raster_line;

   int          errors;
   int          tests;
   logic [31:0] lfsr;

   vicii_top u_dut (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .ce          (ce),
      .rw          (rw),
      .adi         (adi),
      .dbi         (dbi),
      .dbo         (dbo),
      .irq         (irq),
      .ba          (ba),
      .aec         (aec),
      .clk_phi     (clk_phi),
      .raster_x    (raster_x),
      .raster_line (raster_line)
   );

   always #4 clk_dot4x = ~clk_dot4x;

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_byte(output logic [7:0] b);
      for (int i = 0; i < 8; i++) begin
         b[i] = lfsr[31];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic abort_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("Simulation failed");
      $finish;
   endtask

   // returns on the falling clock edge of the first phi high tick
   task automatic wait_phi_rise(output int ticks);
      ticks = 0;
      do begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > 100) abort_timeout("clk_phi low");
      end while (clk_phi !== 1'b0);
      do begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > 100) abort_timeout("clk_phi high");
      end while (clk_phi !== 1'b1);
   endtask

   task automatic wait_phi_fall();
      int ticks;
      ticks = 0;
      do begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > 100) abort_timeout("clk_phi to fall");
      end while (clk_phi !== 1'b0);
   endtask

   task automatic wait_line(input int n);
      int ticks;
      ticks = 0;
      while (raster_line !== n[8:0]) begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > FRAME_TICKS) abort_timeout("a raster line");
      end
   endtask

   task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
      int ticks;
      wait_phi_rise(ticks);
      @(posedge clk_dot4x);
      ce  <= 1'b0;
      rw  <= 1'b0;
      adi <= addr;
      dbi <= data;
      wait_phi_fall();
      @(posedge clk_dot4x);
      ce <= 1'b1;
      rw <= 1'b1;
   endtask

   // line is the beam line during the read phase
   task automatic bus_read(input logic [5:0] addr, output logic [7:0] data,
                           output logic [8:0] line);
      int ticks;
      wait_phi_rise(ticks);
      line = raster_line;
      @(posedge clk_dot4x);
      ce  <= 1'b0;
      rw  <= 1'b1;
      adi <= addr;
      wait_phi_fall();
      data = dbo;
      @(posedge clk_dot4x);
      ce <= 1'b1;
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      $display("test %s done, %0d errors", name, errors - err_before);
   endtask

   task automatic test_reset_clocks();
      int e0;
      int ticks;
      int x0;
      e0 = errors;
      @(negedge clk_dot4x);
      check_val("irq", irq, 0);
      check_val("ba", ba, 1);
      check_val("aec", aec, 0);
      wait_phi_rise(ticks);
      x0 = raster_x;
      wait_phi_rise(ticks);
      check_val("clk_phi period", ticks, 32);
      check_val("raster_x", raster_x, (x0 + 8) % (X_LAST + 1));
      finish_test("reset_clocks", e0);
   endtask

   task automatic test_raster_limits();
      int e0;
      int ticks;
      int line0;
      e0 = errors;
      ticks = 0;
      while (raster_x !== X_LAST) begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > 5000) abort_timeout("raster_x at its maximum");
      end
      line0 = raster_line;
      ticks = 0;
      while (raster_x === X_LAST) begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > 100) abort_timeout("raster_x to wrap");
      end
      check_val("raster_x", raster_x, 0);
      check_val("raster_line", raster_line, (line0 + 1) % (Y_LAST + 1));
      // the line after the last one must be line 0
      wait_line(Y_LAST);
      ticks = 0;
      while (raster_line === Y_LAST) begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > 5000) abort_timeout("the last raster line to end");
      end
      check_val("raster_line", raster_line, 0);
      check_val("raster_x", raster_x, 0);
      finish_test("raster_limits", e0);
   endtask

   task automatic test_registers();
      int e0;
      logic [7:0] wd;
      logic [7:0] rd;
      logic [8:0] line;
      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         rand_byte(wd);
         bus_write(ADDR_RASTER, wd);
         bus_read(ADDR_RASTER, rd, line);
         check_val("raster read", rd, line[7:0]);
      end
      for (int i = 0; i < 4; i++) begin
         rand_byte(wd);
         bus_write(ADDR_CTRL1, wd);
         bus_read(ADDR_CTRL1, rd, line);
         check_val("ctrl1 read", rd, {line[8], wd[6:0]});
      end
      for (int i = 0; i < 4; i++) begin
         rand_byte(wd);
         bus_write(ADDR_IRQ_ENABLE, wd);
         bus_read(ADDR_IRQ_ENABLE, rd, line);
         check_val("irq enable bit 0", rd[0], wd[0]);
      end
      bus_write(ADDR_IRQ_ENABLE, 8'h00);
      bus_write(ADDR_CTRL1, 8'h00);
      finish_test("registers", e0);
   endtask

   task automatic test_raster_irq();
      int e0;
      int ticks;
      logic [7:0] rd;
      logic [8:0] line;
      e0 = errors;
      wait_line(20);
      bus_write(ADDR_CTRL1, 8'h00);
      bus_write(ADDR_RASTER, 8'h05);
      bus_write(ADDR_IRQ_ENABLE, 8'h00);
      bus_write(ADDR_IRQ_STATUS, 8'h01);
      // disabled latch must stay off the irq pin
      ticks = 0;
      while (raster_line !== 9'd6) begin
         @(negedge clk_dot4x);
         ticks++;
         check_val("irq", irq, 0);
         if (ticks > FRAME_TICKS) abort_timeout("raster line 6");
      end
      bus_read(ADDR_IRQ_STATUS, rd, line);
      check_val("irq status bit 0", rd[0], 1);
      check_val("irq status bit 7", rd[7], 0);
      bus_write(ADDR_IRQ_ENABLE, 8'h01);
      @(negedge clk_dot4x);
      check_val("irq", irq, 1);
      bus_write(ADDR_IRQ_STATUS, 8'h01);
      @(negedge clk_dot4x);
      check_val("irq", irq, 0);
      // next frame fires again
      wait_line(100);
      check_val("irq", irq, 0);
      wait_line(5);
      check_val("irq", irq, 0);
      wait_line(6);
      check_val("irq", irq, 1);
      bus_write(ADDR_IRQ_ENABLE, 8'h00);
      bus_write(ADDR_IRQ_STATUS, 8'h01);
      finish_test("raster_irq", e0);
   endtask

   // watch one frame up to the next line 0
   task automatic watch_frame(input logic den_on);
      int   ticks;
      int   cyc;
      int   high_starts;
      logic seen_last;
      logic phi_prev;
      logic ba_exp;
      ticks = 0;
      seen_last = 1'b0;
      phi_prev = clk_phi;
      high_starts = 0;
      forever begin
         @(negedge clk_dot4x);
         ticks++;
         if (ticks > FRAME_TICKS) abort_timeout("the end of a frame");
         cyc = raster_x / 8;
         ba_exp = !(den_on && raster_line >= 48 && raster_line < 248 &&
                    raster_line[2:0] == 3'd3 && cyc >= 12 && cyc <= 54);
         check_val("ba", ba, ba_exp);
         if (ba) begin
            high_starts = 0;
         end else if (clk_phi && !phi_prev) begin
            high_starts++;
         end
         if (!ba && clk_phi && high_starts >= 3) begin
            check_val("aec", aec, 0);
         end
         phi_prev = clk_phi;
         if (raster_line == Y_LAST) seen_last = 1'b1;
         if (seen_last && raster_line == 0) break;
      end
   endtask

   task automatic test_badline();
      int e0;
      e0 = errors;
      wait_line(0);
      // den on with yscroll 3
      bus_write(ADDR_CTRL1, 8'h13);
      watch_frame(1'b1);
      bus_write(ADDR_CTRL1, 8'h03);
      watch_frame(1'b0);
      finish_test("badline", e0);
   endtask

   initial begin
      clk_dot4x = 1'b0;
      rst = 1'b1;
      ce = 1'b1;
      rw = 1'b1;
      adi = 6'h00;
      dbi = 8'h00;
      errors = 0;
      tests = 0;
      lfsr = 32'd89682;
      repeat (2) @(posedge clk_dot4x);
      rst <= 1'b0;
      test_reset_clocks();
      test_raster_limits();
      test_registers();
      test_raster_irq();
      test_badline();
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vicii_lite.f
src/vicii_pkg.sv
src/vicii_timing.sv
src/vicii_raster.sv
src/vicii_registers.sv
src/vicii_badline.sv
src/vicii_top.sv
bench/vicii_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vicii_lite.f --top-module vicii_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vvicii_tb)"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
